// ==== design/fp_pkg.sv ====
// Shared widths and types for the single-precision add/sub pipeline
// IEEE 754 binary32 layout, no NaN, infinity or subnormal support
// Significands carry the hidden bit plus three guard bits below the fraction
`default_nettype none

package fp_pkg;

    // Binary32 field widths
    localparam int word_bits  = 32;
    localparam int exp_bits   = 8;
    localparam int mant_bits  = 23;

    // Extra bits kept below the fraction during alignment
    localparam int guard_bits = 3;

    // Hidden bit + fraction + guard bits
    localparam int sig_bits   = 1 + mant_bits + guard_bits;

    // Alignment shift amount, wide enough for max_shift
    localparam int shift_bits = 5;

    // Shifting by the full significand width already clears it
    localparam int max_shift  = sig_bits;

    // Edges from an enabled sample to data_reg_c, result register included
    localparam int pipe_depth = 5;

    // Packed float
    typedef logic [word_bits-1:0]  word_t;

    // Biased exponent
    typedef logic [exp_bits-1:0]   exp_t;

    // Aligned significand with guard bits
    typedef logic [sig_bits-1:0]   sig_t;

    // Alignment amount
    typedef logic [shift_bits-1:0] shift_t;

endpackage

`default_nettype wire

// ==== design/fp_align.sv ====
// Exponent compare, operand swap and significand alignment, two register stages
// A zero exponent field reads as exact zero and its fraction is ignored
// Shift saturates at max_shift; bits pushed past the guard bits are lost
`timescale 1ns/1ns
`default_nettype none

module fp_align (
    input  logic          clk,
    input  logic          arst_n,
    input  fp_pkg::word_t a,
    input  fp_pkg::word_t b,
    input  logic          operation_select,
    output fp_pkg::sig_t  big_sig,
    output fp_pkg::sig_t  small_sig,
    output logic          big_sign,
    output logic          small_sign,
    output fp_pkg::exp_t  big_exp
);

    // Unpacked operand fields
    fp_pkg::exp_t                 a_exp, b_exp;
    logic [fp_pkg::mant_bits-1:0] a_man, b_man;
    logic                         a_sign, b_sign;
    fp_pkg::sig_t                 a_sig, b_sig;

    // Compare results
    logic                         a_is_big;
    fp_pkg::exp_t                 exp_diff;
    fp_pkg::shift_t               shift_amt;

    // Stage 1 state
    fp_pkg::sig_t                 s1_big_sig, s1_small_sig;
    logic                         s1_big_sign, s1_small_sign;
    fp_pkg::exp_t                 s1_big_exp;
    fp_pkg::shift_t               s1_shift;

    assign a_exp  = a[fp_pkg::mant_bits +: fp_pkg::exp_bits];
    assign b_exp  = b[fp_pkg::mant_bits +: fp_pkg::exp_bits];
    assign a_man  = a[fp_pkg::mant_bits-1:0];
    assign b_man  = b[fp_pkg::mant_bits-1:0];
    assign a_sign = a[fp_pkg::word_bits-1];
    // Subtract is add with b negated
    assign b_sign = b[fp_pkg::word_bits-1] ^ operation_select;

    // Hidden bit only when the exponent field is nonzero
    assign a_sig = (a_exp != '0) ? {1'b1, a_man, {fp_pkg::guard_bits{1'b0}}} : '0;
    assign b_sig = (b_exp != '0) ? {1'b1, b_man, {fp_pkg::guard_bits{1'b0}}} : '0;

    // Exponent first, then significand; ties go to a
    assign a_is_big = (a_exp > b_exp) || ((a_exp == b_exp) && (a_sig >= b_sig));
    assign exp_diff = a_is_big ? (a_exp - b_exp) : (b_exp - a_exp);

    // Large gaps clamp, the small operand then aligns to nothing
    assign shift_amt = (exp_diff >= fp_pkg::exp_t'(fp_pkg::max_shift)) ?
                       fp_pkg::shift_t'(fp_pkg::max_shift) :
                       exp_diff[fp_pkg::shift_bits-1:0];

    // Stage 1, swap and shift amount
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_big_sig    <= '0;
            s1_small_sig  <= '0;
            s1_big_sign   <= 1'b0;
            s1_small_sign <= 1'b0;
            s1_big_exp    <= '0;
            s1_shift      <= '0;
        end else begin
            s1_big_sig    <= a_is_big ? a_sig : b_sig;
            s1_small_sig  <= a_is_big ? b_sig : a_sig;
            s1_big_sign   <= a_is_big ? a_sign : b_sign;
            s1_small_sign <= a_is_big ? b_sign : a_sign;
            s1_big_exp    <= a_is_big ? a_exp : b_exp;
            s1_shift      <= shift_amt;
        end
    end

    // Stage 2, aligned small significand
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            big_sig    <= '0;
            small_sig  <= '0;
            big_sign   <= 1'b0;
            small_sign <= 1'b0;
            big_exp    <= '0;
        end else begin
            big_sig    <= s1_big_sig;
            small_sig  <= s1_small_sig >> s1_shift;
            big_sign   <= s1_big_sign;
            small_sign <= s1_small_sign;
            big_exp    <= s1_big_exp;
        end
    end

endmodule

`default_nettype wire

// ==== design/fp_mant_add.sv ====
// Magnitude add or subtract of the aligned significands, one register stage
// Expects big_sig >= small_sig, which the alignment swap guarantees
`timescale 1ns/1ns
`default_nettype none

module fp_mant_add (
    input  logic         clk,
    input  logic         arst_n,
    input  fp_pkg::sig_t big_sig,
    input  fp_pkg::sig_t small_sig,
    input  logic         big_sign,
    input  logic         small_sign,
    input  fp_pkg::exp_t big_exp,
    output fp_pkg::sig_t sum_sig,
    output logic         carry,
    output logic         sum_sign,
    output fp_pkg::exp_t sum_exp
);

    // Signs differ, so magnitudes subtract
    logic                       eff_sub;
    // One extra bit for the carry out of an add
    logic [fp_pkg::sig_bits:0]  raw_sum;

    assign eff_sub = big_sign ^ small_sign;

    // Difference never borrows, top bit stays clear on subtract
    always_comb begin
        if (eff_sub) begin
            raw_sum = {1'b0, big_sig} - {1'b0, small_sig};
        end else begin
            raw_sum = {1'b0, big_sig} + {1'b0, small_sig};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_sig  <= '0;
            carry    <= 1'b0;
            sum_sign <= 1'b0;
            sum_exp  <= '0;
        end else begin
            sum_sig  <= raw_sum[fp_pkg::sig_bits-1:0];
            carry    <= raw_sum[fp_pkg::sig_bits];
            // Larger magnitude decides the sign
            sum_sign <= big_sign;
            sum_exp  <= big_exp;
        end
    end

endmodule

`default_nettype wire

// ==== design/fp_normalize.sv ====
// Normalization and packing, one register stage
// Rounds toward zero by dropping the guard bits
// Zero and underflowed results become +0; exponent overflow is not handled
`timescale 1ns/1ns
`default_nettype none

module fp_normalize (
    input  logic          clk,
    input  logic          arst_n,
    input  fp_pkg::sig_t  sum_sig,
    input  logic          carry,
    input  logic          sum_sign,
    input  fp_pkg::exp_t  sum_exp,
    output fp_pkg::word_t result
);

    // Leading zeros above the first set bit, sig_bits when all clear
    fp_pkg::shift_t lead_zeros;

    // Normalized significand, hidden bit at the top
    fp_pkg::sig_t   norm_sig;
    fp_pkg::exp_t   norm_exp;
    logic           flush;

    // Priority encoder, highest set bit wins as the loop climbs
    always_comb begin
        lead_zeros = fp_pkg::shift_t'(fp_pkg::sig_bits);
        for (int i = 0; i < fp_pkg::sig_bits; i++) begin
            if (sum_sig[i]) begin
                lead_zeros = fp_pkg::shift_t'(fp_pkg::sig_bits - 1 - i);
            end
        end
    end

    always_comb begin
        // Default path after a cancelling subtract or a plain add
        norm_sig = sum_sig << lead_zeros;
        norm_exp = sum_exp - fp_pkg::exp_t'(lead_zeros);
        // Exponent would reach zero or go negative
        flush    = (sum_sig == '0) || (sum_exp <= fp_pkg::exp_t'(lead_zeros));

        // Carry out, one place right and exponent up
        if (carry) begin
            norm_sig = {carry, sum_sig[fp_pkg::sig_bits-1:1]};
            norm_exp = sum_exp + fp_pkg::exp_t'(1);
            flush    = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (flush) begin
            // Always +0, sign dropped
            result <= '0;
        end else begin
            // Hidden bit and guard bits fall away here
            result <= {sum_sign, norm_exp,
                       norm_sig[fp_pkg::sig_bits-2 -: fp_pkg::mant_bits]};
        end
    end

endmodule

`default_nettype wire

// ==== design/fp_add_sub.sv ====
// Pipelined binary32 add/subtract, operation_select high means a - b
// Operands and operation are zeroed while en is low
// data_reg_c updates pipe_depth edges after an enabled sample and holds otherwise
// No back-pressure; a new sample may enter on every clock
`timescale 1ns/1ns
`default_nettype none

module fp_add_sub (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          en,
    input  fp_pkg::word_t a,
    input  fp_pkg::word_t b,
    input  logic          operation_select,
    output fp_pkg::word_t data_reg_c
);

    // Gated inputs
    fp_pkg::word_t a_gated, b_gated;
    logic          op_gated;

    // Align to add
    fp_pkg::sig_t  big_sig, small_sig;
    logic          big_sign, small_sign;
    fp_pkg::exp_t  big_exp;

    // Add to normalize
    fp_pkg::sig_t  sum_sig;
    logic          carry, sum_sign;
    fp_pkg::exp_t  sum_exp;

    fp_pkg::word_t result;

    // One bit per stage ahead of the result register, which is the last stage
    logic [fp_pkg::pipe_depth-2:0] en_line;

    assign a_gated  = en ? a : '0;
    assign b_gated  = en ? b : '0;
    assign op_gated = en & operation_select;

    fp_align i_align (
        .clk              (clk),
        .arst_n           (arst_n),
        .a                (a_gated),
        .b                (b_gated),
        .operation_select (op_gated),
        .big_sig          (big_sig),
        .small_sig        (small_sig),
        .big_sign         (big_sign),
        .small_sign       (small_sign),
        .big_exp          (big_exp)
    );

    fp_mant_add i_mant_add (
        .clk        (clk),
        .arst_n     (arst_n),
        .big_sig    (big_sig),
        .small_sig  (small_sig),
        .big_sign   (big_sign),
        .small_sign (small_sign),
        .big_exp    (big_exp),
        .sum_sig    (sum_sig),
        .carry      (carry),
        .sum_sign   (sum_sign),
        .sum_exp    (sum_exp)
    );

    fp_normalize i_normalize (
        .clk      (clk),
        .arst_n   (arst_n),
        .sum_sig  (sum_sig),
        .carry    (carry),
        .sum_sign (sum_sign),
        .sum_exp  (sum_exp),
        .result   (result)
    );

    // Enable travels beside the data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_line <= '0;
        end else begin
            en_line <= {en_line[fp_pkg::pipe_depth-3:0], en};
        end
    end

    // Result register, loads only for enabled samples
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_reg_c <= '0;
        end else if (en_line[fp_pkg::pipe_depth-2]) begin
            data_reg_c <= result;
        end
    end

endmodule

`default_nettype wire

// ==== include/fp_model.svh ====
// Expected result of the add/sub pipeline for one operand pair
// Zero exponent means zero; smaller operand truncated to three guard bits
// Exact add or subtract, then truncation to 24 bits; zero or underflow gives +0
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

function automatic fp_pkg::word_t fp_model(input fp_pkg::word_t a,
                                           input fp_pkg::word_t b,
                                           input logic          sub);
    // Index of the carry bit; hidden bit sits one below
    localparam int top = fp_pkg::mant_bits + fp_pkg::guard_bits + 1;
    logic [top:0] sig_a, sig_b, big_s, small_s, sum;
    int           exp_a, exp_b, big_e, msb, res_e;
    logic         sign_a, sign_b, big_sign, small_sign;

    exp_a  = a[fp_pkg::mant_bits +: fp_pkg::exp_bits];
    exp_b  = b[fp_pkg::mant_bits +: fp_pkg::exp_bits];
    sign_a = a[fp_pkg::mant_bits + fp_pkg::exp_bits];
    sign_b = b[fp_pkg::mant_bits + fp_pkg::exp_bits] ^ sub;
    sig_a  = (exp_a != 0) ? {2'b01, a[fp_pkg::mant_bits-1:0], {fp_pkg::guard_bits{1'b0}}} : '0;
    sig_b  = (exp_b != 0) ? {2'b01, b[fp_pkg::mant_bits-1:0], {fp_pkg::guard_bits{1'b0}}} : '0;

    if ((exp_a > exp_b) || ((exp_a == exp_b) && (sig_a >= sig_b))) begin
        big_s      = sig_a;
        big_e      = exp_a;
        big_sign   = sign_a;
        small_sign = sign_b;
        small_s    = sig_b >> (exp_a - exp_b);
    end else begin
        big_s      = sig_b;
        big_e      = exp_b;
        big_sign   = sign_b;
        small_sign = sign_a;
        small_s    = sig_a >> (exp_b - exp_a);
    end

    sum = (big_sign == small_sign) ? (big_s + small_s) : (big_s - small_s);
    if (sum == '0) begin
        return '0;
    end

    msb = 0;
    for (int i = 0; i <= top; i++) begin
        if (sum[i]) begin
            msb = i;
        end
    end
    res_e = big_e + msb - (top - 1);
    if (res_e <= 0) begin
        return '0;
    end

    sum = sum << (top - msb);
    return {big_sign, res_e[fp_pkg::exp_bits-1:0], sum[top-1 -: fp_pkg::mant_bits]};
endfunction

`endif

// ==== bench/fp_add_sub_assert.sv ====
// Concurrent checks on the add/sub pipeline, bound into fp_add_sub
// Keeps its own copy of the last pipe_depth input samples
// Expected values come from the fp_model reference function
`timescale 1ns/1ns
`default_nettype none

module fp_add_sub_assert (
    input logic          clk,
    input logic          arst_n,
    input logic          en,
    input fp_pkg::word_t a,
    input fp_pkg::word_t b,
    input logic          operation_select,
    input fp_pkg::word_t data_reg_c
);

    `include "fp_model.svh"

    // Oldest slot of the input history
    localparam int last = fp_pkg::pipe_depth - 1;

    // Failed assertions so far, read by the testbench
    int                            fail_count = 0;

    // Input samples, slot i holds the sample from i+1 edges back
    fp_pkg::word_t                 a_hist [fp_pkg::pipe_depth];
    fp_pkg::word_t                 b_hist [fp_pkg::pipe_depth];
    logic [fp_pkg::pipe_depth-1:0] op_hist;
    logic [fp_pkg::pipe_depth-1:0] en_hist;

    // Set once the first enabled result has landed
    logic                          seen_result;
    fp_pkg::word_t                 expected;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < fp_pkg::pipe_depth; i++) begin
                a_hist[i] <= '0;
                b_hist[i] <= '0;
            end
            op_hist     <= '0;
            en_hist     <= '0;
            seen_result <= 1'b0;
        end else begin
            a_hist[0] <= a;
            b_hist[0] <= b;
            for (int i = 1; i < fp_pkg::pipe_depth; i++) begin
                a_hist[i] <= a_hist[i-1];
                b_hist[i] <= b_hist[i-1];
            end
            op_hist <= {op_hist[last-1:0], operation_select};
            en_hist <= {en_hist[last-1:0], en};
            if (en_hist[last]) begin
                seen_result <= 1'b1;
            end
        end
    end

    // Model result for the sample now reaching the output
    always_comb begin
        expected = fp_model(a_hist[last], b_hist[last], op_hist[last]);
    end

    // Enabled sample arrives with the model value
    result_matches: assert property (
        @(posedge clk) disable iff (!arst_n)
        en_hist[last] |-> (data_reg_c == expected)
    ) else begin
        fail_count++;
        $error("CHECK FAILED at %0t: data_reg_c %h, expected %h (a %h b %h sub %0b)",
               $time, $sampled(data_reg_c), $sampled(expected),
               $sampled(a_hist[last]), $sampled(b_hist[last]), $sampled(op_hist[last]));
    end

    // No enabled sample arriving, output register holds
    result_holds: assert property (
        @(posedge clk) disable iff (!arst_n)
        !en_hist[last] |-> $stable(data_reg_c)
    ) else begin
        fail_count++;
        $error("CHECK FAILED at %0t: data_reg_c changed to %h without an enabled sample",
               $time, $sampled(data_reg_c));
    end

    // Still zero from reset until the first result
    idle_after_reset: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!seen_result && !en_hist[last]) |-> (data_reg_c == '0)
    ) else begin
        fail_count++;
        $error("CHECK FAILED at %0t: data_reg_c is %h before any result",
               $time, $sampled(data_reg_c));
    end

endmodule

bind fp_add_sub fp_add_sub_assert i_checker (
    .clk              (clk),
    .arst_n           (arst_n),
    .en               (en),
    .a                (a),
    .b                (b),
    .operation_select (operation_select),
    .data_reg_c       (data_reg_c)
);

`default_nettype wire

// ==== bench/tb_fp_add_sub.sv ====
// Random and directed stimulus for the add/sub pipeline
// Exponent fields stay within 64..190, so no result can overflow
// Results are checked by the bound fp_add_sub_assert module
`timescale 1ns/1ns
`default_nettype none

module tb_fp_add_sub;

    localparam int          seed        = 83681;
    localparam logic [31:0] lfsr_taps   = 32'h8020_0003;
    localparam int          idle_count  = 8;
    localparam int          near_count  = 200;
    localparam int          close_count = 100;
    localparam int          edge_count  = 60;
    localparam int          burst_count = 80;
    localparam int          drain       = fp_pkg::pipe_depth + 2;
    // One cycle per sample plus drain + 1 at the end of each test
    localparam int          cycle_limit = 2 + idle_count + near_count + close_count
                                        + edge_count + burst_count + 5 * (drain + 1)
                                        + fp_pkg::pipe_depth + 100;

    logic          clk              = 1'b0;
    logic          arst_n           = 1'b0;
    logic          en               = 1'b0;
    fp_pkg::word_t a                = '0;
    fp_pkg::word_t b                = '0;
    logic          operation_select = 1'b0;
    fp_pkg::word_t data_reg_c;

    logic [31:0]   lfsr_state   = seed;
    int            cycles       = 0;
    int            samples      = 0;
    int            tests_done   = 0;
    int            fails_before = 0;

    fp_add_sub i_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .en               (en),
        .a                (a),
        .b                (b),
        .operation_select (operation_select),
        .data_reg_c       (data_reg_c)
    );

    always #20 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic fp_pkg::word_t make_float(input logic s, input int e,
                                                 input logic [fp_pkg::mant_bits-1:0] m);
        return {s, fp_pkg::exp_t'(e), m};
    endfunction

    // One sample driven on the rising edge
    task automatic send(input logic s_en, input fp_pkg::word_t s_a,
                        input fp_pkg::word_t s_b, input logic s_op);
        @(posedge clk);
        en               <= s_en;
        a                <= s_a;
        b                <= s_b;
        operation_select <= s_op;
        if (s_en) begin
            samples++;
        end
    endtask

    // Operands with exponents within 3 of each other
    task automatic random_near(output fp_pkg::word_t x, output fp_pkg::word_t y);
        int                           ex, ey;
        logic                         sx, sy;
        logic [fp_pkg::mant_bits-1:0] mx, my;
        ex = 67 + int'(rand_bits(7) % 121);
        ey = ex + int'(rand_bits(3) % 7) - 3;
        sx = rand_bits(1);
        sy = rand_bits(1);
        mx = rand_bits(fp_pkg::mant_bits);
        my = rand_bits(fp_pkg::mant_bits);
        x  = make_float(sx, ex, mx);
        y  = make_float(sy, ey, my);
    endtask

    // Let the pipeline empty, then report the test
    task automatic finish_test(input string name);
        int new_fails;
        send(1'b0, '0, '0, 1'b0);
        repeat (drain) @(posedge clk);
        new_fails    = i_dut.i_checker.fail_count - fails_before;
        fails_before = i_dut.i_checker.fail_count;
        tests_done++;
        $display("%-12s done at %0t ns, %0d failures", name, $time, new_fails);
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        fp_pkg::word_t                x, y;
        int                           ea, eb, tmp;
        logic                         sa, sb, op, bit_en;
        logic [1:0]                   mode;
        logic [fp_pkg::mant_bits-1:0] ma, mb;
        int                           total_fails;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Random operands with en low must leave the output at zero
        for (int i = 0; i < idle_count; i++) begin
            x  = rand_bits(32);
            y  = rand_bits(32);
            op = rand_bits(1);
            send(1'b0, x, y, op);
        end
        finish_test("reset_idle");

        // Back-to-back near exponents including carry cases
        for (int i = 0; i < near_count; i++) begin
            random_near(x, y);
            op = rand_bits(1);
            send(1'b1, x, y, op);
        end
        finish_test("near_exp");

        // Effective subtraction of close magnitudes
        for (int i = 0; i < close_count; i++) begin
            ea   = 65 + int'(rand_bits(7) % 126);
            ma   = rand_bits(fp_pkg::mant_bits);
            sa   = rand_bits(1);
            op   = rand_bits(1);
            sb   = ~sa ^ op;
            mode = rand_bits(2);
            eb   = ea;
            case (mode)
                2'd0: mb = ma;
                2'd1: mb = ma ^ rand_bits(4);
                2'd2: mb = ma ^ rand_bits(16);
                default: begin
                    eb = ea - 1;
                    mb = '1 ^ rand_bits(8);
                end
            endcase
            send(1'b1, make_float(sa, ea, ma), make_float(sb, eb, mb), op);
        end
        finish_test("close_sub");

        // Zero operands and gaps past the guard bits
        for (int i = 0; i < edge_count; i++) begin
            mode = rand_bits(2);
            sa   = rand_bits(1);
            sb   = rand_bits(1);
            op   = rand_bits(1);
            ma   = rand_bits(fp_pkg::mant_bits);
            mb   = rand_bits(fp_pkg::mant_bits);
            ea   = 64 + int'(rand_bits(7) % 127);
            eb   = 64 + int'(rand_bits(7) % 127);
            if (mode == 2'd0) begin
                ea = 0;
            end else if (mode == 2'd1) begin
                eb = 0;
            end else if (mode == 2'd2) begin
                ea = 0;
                eb = 0;
            end else begin
                ea = 128 + int'(rand_bits(6) % 63);
                eb = ea - 27 - int'(rand_bits(6) % 37);
                if (rand_bits(1)) begin
                    tmp = ea;
                    ea  = eb;
                    eb  = tmp;
                end
            end
            send(1'b1, make_float(sa, ea, ma), make_float(sb, eb, mb), op);
        end
        finish_test("zero_gap");

        // Alternate cycles first, then random en
        for (int i = 0; i < burst_count; i++) begin
            random_near(x, y);
            op     = rand_bits(1);
            bit_en = (i < burst_count / 3) ? i[0] : rand_bits(1);
            send(bit_en, x, y, op);
        end
        finish_test("en_burst");

        total_fails = i_dut.i_checker.fail_count;
        $display("Summary: %0d tests, %0d enabled samples, %0d failures",
                 tests_done, samples, total_fails);
        if (total_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
design/fp_pkg.sv
design/fp_align.sv
design/fp_mant_add.sv
design/fp_normalize.sv
design/fp_add_sub.sv
bench/fp_add_sub_assert.sv
bench/tb_fp_add_sub.sv

// ==== Bender.yml ====
package:
  name: fp_add_sub

sources:
  - files:
      - design/fp_pkg.sv
      - design/fp_align.sv
      - design/fp_mant_add.sv
      - design/fp_normalize.sv
      - design/fp_add_sub.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/fp_add_sub_assert.sv
      - bench/tb_fp_add_sub.sv
